// File: design/fifo.sv
// SDMAC FIFO of eight longwords with lane writes, entry pointers and status
`timescale 1ns/10ps
`default_nettype none

`include "fifo_config.svh"

module fifo (
  input  wire logic                       clk,
  input  wire logic                       arst_n,
  input  wire logic                       flush,      // RST_FIFO equivalent
  input  wire logic                       ld_upper,
  input  wire logic                       ld_lower,
  input  wire logic                       ld_byte,
  input  wire logic                       commit,     // Advance next in
  input  wire logic                       pop,        // Advance next out
  input  wire logic                       mid25,
  input  wire sdmac_reg_pkg::bp_action_e  bp_action,
  input  wire fifo_types_pkg::long_word_t wr_data,
  output fifo_types_pkg::long_word_t      rd_data,    // Entry at next out
  output logic                            fifo_full,
  output logic                            fifo_empty,
  output logic                            bo_eq0,     // First byte lane
  output logic                            bo_eq3,     // Last byte lane
  output fifo_types_pkg::byte_ptr_t       byte_ptr
);
  import fifo_types_pkg::*;

  localparam int LANE_W = $bits(byte_t);
  localparam int LANES  = $bits(lane_en_t);

  long_word_t mem [`FIFO_DEPTH];   // Storage, no reset
  fifo_ptr_t  next_in;             // Entry being written
  fifo_ptr_t  next_out;            // Entry being read
  lane_en_t   lanes;

  fifo_write_strobes u_write_strobes (
    .byte_ptr (byte_ptr),
    .ld_upper (ld_upper),
    .ld_lower (ld_lower),
    .ld_byte  (ld_byte),
    .lanes    (lanes)
  );

  fifo_fill_ctr u_fill_ctr (
    .clk        (clk),
    .arst_n     (arst_n),
    .flush      (flush),
    .commit     (commit),
    .pop        (pop),
    .fifo_full  (fifo_full),
    .fifo_empty (fifo_empty)
  );

  fifo_byte_ptr u_byte_ptr (
    .clk    (clk),
    .arst_n (arst_n),
    .flush  (flush),
    .mid25  (mid25),
    .action (bp_action),
    .ptr    (byte_ptr)
  );

  // Entry pointers wrap at the depth
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      next_in  <= '0;
      next_out <= '0;
    end else if (flush) begin
      next_in  <= '0;
      next_out <= '0;
    end else begin
      if (commit) next_in  <= next_in + 1'b1;
      if (pop)    next_out <= next_out + 1'b1;
    end
  end

  // Clocked lane writes replace the negedge strobes
  always_ff @(posedge clk) begin
    for (int i = 0; i < LANES; i++) begin
      if (lanes[i]) mem[next_in][i*LANE_W +: LANE_W] <= wr_data[i*LANE_W +: LANE_W];
    end
  end

  assign rd_data = mem[next_out];                 // Asynchronous read
  assign bo_eq0  = (byte_ptr == byte_ptr_t'(0));
  assign bo_eq3  = (byte_ptr == byte_ptr_t'(3));

  // Counter flags and pointers must agree at both ends
  a_ptrs_meet: assert property (@(posedge clk) disable iff (!arst_n)
    (fifo_empty || fifo_full) |-> (next_in == next_out))
    else $error("fifo: pointers disagree with fill count");

endmodule

`default_nettype wire

// File: design/fifo_byte_ptr.sv
// SDMAC FIFO byte pointer with increment, ACR preset and flush
`timescale 1ns/10ps
`default_nettype none

module fifo_byte_ptr (
  input  wire logic                      clk,
  input  wire logic                      arst_n,
  input  wire logic                      flush,    // Back to lane 0
  input  wire logic                      mid25,    // Preset to 2 when set
  input  wire sdmac_reg_pkg::bp_action_e action,
  output fifo_types_pkg::byte_ptr_t      ptr
);
  import fifo_types_pkg::*;
  import sdmac_reg_pkg::*;

  localparam byte_ptr_t PRESET_MID = byte_ptr_t'(2);   // Half entry already there
  localparam byte_ptr_t PRESET_LOW = byte_ptr_t'(0);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ptr <= '0;
    end else if (flush) begin
      ptr <= '0;
    end else begin
      case (action)
        BP_PRESET: ptr <= mid25 ? PRESET_MID : PRESET_LOW;
        BP_INC:    ptr <= ptr + 1'b1;                  // Wraps 3 to 0 on commit
        default:   ptr <= ptr;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: design/fifo_config.svh
// SDMAC FIFO configuration macros for entry count, longword width and ACR offset
`ifndef FIFO_CONFIG_SVH
`define FIFO_CONFIG_SVH

// Number of longword entries, 32 bytes in total
`define FIFO_DEPTH 8

// Longword width in bits
`define FIFO_DATA_W 32

// ACR register offset, a write here presets the byte pointer
`define ACR_OFFSET 8'h0C

`endif

// File: design/fifo_ctrl.sv
// SDMAC FIFO controller mapping word, byte and read handshakes plus ACR writes to strobes
`timescale 1ns/10ps
`default_nettype none

`include "fifo_config.svh"

module fifo_ctrl (
  input  wire logic                       word_valid,    // CPU side longword offered
  input  wire logic                       byte_valid,    // SCSI side byte offered
  input  wire logic                       rd_ready,      // Reader takes rd_data
  input  wire logic                       load_upper,    // Word write covers bits 31:16
  input  wire logic                       load_lower,    // Word write covers bits 15:0
  input  wire logic                       reg_wr,        // Register write strobe
  input  wire logic                       reg_mid25,     // Preset value select
  input  wire logic                       fifo_full,
  input  wire logic                       fifo_empty,
  input  wire fifo_types_pkg::long_word_t word_data,
  input  wire fifo_types_pkg::byte_t      byte_data,
  input  wire sdmac_reg_pkg::reg_addr_t   reg_addr,
  input  wire fifo_types_pkg::byte_ptr_t  byte_ptr,      // Lane of the entry in progress
  output logic                            word_ready,
  output logic                            byte_ready,
  output logic                            rd_valid,
  output logic                            ld_upper,      // LHWORD equivalent
  output logic                            ld_lower,      // LLWORD equivalent
  output logic                            ld_byte,       // LBYTE equivalent
  output logic                            commit,        // INCNI plus INCFIFO
  output logic                            pop,           // INCNO plus DECFIFO
  output sdmac_reg_pkg::bp_action_e       bp_action,
  output fifo_types_pkg::long_word_t      wr_lanes_data  // Data presented to all lanes
);
  import fifo_types_pkg::*;
  import sdmac_reg_pkg::*;

  localparam byte_ptr_t LAST_LANE = byte_ptr_t'(3);        // Bits 7:0, entry complete
  localparam reg_addr_t ACR_ADDR  = reg_addr_t'(`ACR_OFFSET);
  localparam int        LANES     = `FIFO_DATA_W / $bits(byte_t);

  logic word_xfer;   // Longword accepted this cycle
  logic byte_xfer;   // Byte accepted this cycle
  logic acr_hit;     // Write lands on the ACR

  always_comb begin
    // Words only start on a fresh entry
    word_ready = !fifo_full && (byte_ptr == '0);
    word_xfer  = word_valid && word_ready;
    byte_ready = !fifo_full && !word_xfer;                 // Word write wins a tie
    byte_xfer  = byte_valid && byte_ready;

    rd_valid = !fifo_empty;
    pop      = rd_valid && rd_ready;

    ld_upper = word_xfer && load_upper;
    ld_lower = word_xfer && load_lower;
    ld_byte  = byte_xfer;

    // Fourth byte closes the entry just like a word write
    commit = word_xfer || (byte_xfer && (byte_ptr == LAST_LANE));

    acr_hit = reg_wr && (reg_addr == ACR_ADDR);
    if (acr_hit) begin
      bp_action = BP_PRESET;                               // Preset beats increment
    end else if (byte_xfer) begin
      bp_action = BP_INC;
    end else begin
      bp_action = BP_HOLD;
    end

    // Byte copied to every lane, lane enables pick the one written
    wr_lanes_data = byte_xfer ? long_word_t'({LANES{byte_data}}) : word_data;
  end

endmodule

`default_nettype wire

// File: design/fifo_fill_ctr.sv
// SDMAC FIFO occupancy counter producing the full and empty flags
`timescale 1ns/10ps
`default_nettype none

`include "fifo_config.svh"

module fifo_fill_ctr (
  input  wire logic clk,
  input  wire logic arst_n,
  input  wire logic flush,       // Empties the FIFO at the next edge
  input  wire logic commit,      // Entry finished, count up
  input  wire logic pop,         // Entry read, count down
  output logic      fifo_full,
  output logic      fifo_empty
);
  import fifo_types_pkg::*;

  localparam fill_cnt_t FULL_CNT = fill_cnt_t'(`FIFO_DEPTH);

  fill_cnt_t count;  // Occupied entries

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      count <= '0;
    end else if (flush) begin
      count <= '0;                                  // Flush overrides traffic
    end else if (commit && !pop) begin
      count <= count + 1'b1;
    end else if (pop && !commit) begin
      count <= count - 1'b1;
    end                                             // Both or neither, no change
  end

  assign fifo_full  = (count == FULL_CNT);
  assign fifo_empty = (count == '0);

  // Ready and valid gating upstream must keep the count in range
  a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
    !(commit && !pop && fifo_full))
    else $error("fifo_fill_ctr: overflow");

  a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n)
    !(pop && fifo_empty))
    else $error("fifo_fill_ctr: underflow");

endmodule

`default_nettype wire

// File: design/fifo_types_pkg.sv
// FIFO data-path types for longwords, SCSI bytes, lane enables and pointers
`default_nettype none

`include "fifo_config.svh"

package fifo_types_pkg;

  typedef logic [`FIFO_DATA_W-1:0] long_word_t;             // One FIFO entry
  typedef logic [7:0] byte_t;                               // SCSI side byte

  // One write enable per byte lane, bit 3 covers bits 31:24
  typedef logic [`FIFO_DATA_W/8-1:0] lane_en_t;

  typedef logic [$clog2(`FIFO_DEPTH)-1:0] fifo_ptr_t;       // Next in / next out index
  typedef logic [$clog2(`FIFO_DEPTH+1)-1:0] fill_cnt_t;     // Occupancy, 0 up to depth

  // Byte lane of the entry being built, 0 is the top byte
  typedef logic [1:0] byte_ptr_t;

endpackage

`default_nettype wire

// File: design/fifo_write_strobes.sv
// SDMAC FIFO lane write enable decode from word loads and the byte pointer
`timescale 1ns/10ps
`default_nettype none

module fifo_write_strobes (
  input  wire fifo_types_pkg::byte_ptr_t byte_ptr,   // Lane for byte loads
  input  wire logic                      ld_upper,   // Word write, top half
  input  wire logic                      ld_lower,   // Word write, bottom half
  input  wire logic                      ld_byte,    // Single byte write
  output fifo_types_pkg::lane_en_t       lanes       // Bit 3 is bits 31:24
);
  import fifo_types_pkg::*;

  localparam lane_en_t TOP_LANE = lane_en_t'(4'b1000);  // Pointer 0 lands here

  lane_en_t byte_lane;   // One hot lane chosen by the pointer
  lane_en_t word_lanes;  // Lane pairs from the word loads

  always_comb begin
    byte_lane  = TOP_LANE >> byte_ptr;                   // Big-endian byte order
    word_lanes = {{2{ld_upper}}, {2{ld_lower}}};         // UU/UM and LM/LL pairs
    lanes      = ({$bits(lane_en_t){ld_byte}} & byte_lane) | word_lanes;

    // Controller arbitration keeps the two paths apart
    assert (!(ld_byte && (ld_upper || ld_lower)))
      else $error("fifo_write_strobes: byte and word load together");
  end

endmodule

`default_nettype wire

// File: design/sdmac_fifo_top.sv
// SDMAC FIFO top joining the handshake controller and the longword FIFO
`timescale 1ns/10ps
`default_nettype none

module sdmac_fifo_top (
  input  wire logic                       clk,
  input  wire logic                       arst_n,
  input  wire logic                       word_valid,   // CPU side
  output logic                            word_ready,
  input  wire fifo_types_pkg::long_word_t word_data,
  input  wire logic                       load_upper,
  input  wire logic                       load_lower,
  input  wire logic                       byte_valid,   // SCSI side
  output logic                            byte_ready,
  input  wire fifo_types_pkg::byte_t      byte_data,
  output logic                            rd_valid,     // Read side
  input  wire logic                       rd_ready,
  output fifo_types_pkg::long_word_t      rd_data,
  input  wire logic                       reg_wr,       // Register bus
  input  wire sdmac_reg_pkg::reg_addr_t   reg_addr,
  input  wire logic                       reg_mid25,
  input  wire logic                       fifo_flush,
  output logic                            fifo_full,
  output logic                            fifo_empty,
  output logic                            bo_eq0,
  output logic                            bo_eq3,
  output fifo_types_pkg::byte_ptr_t       byte_ptr
);
  import fifo_types_pkg::*;
  import sdmac_reg_pkg::*;

  logic       ld_upper;
  logic       ld_lower;
  logic       ld_byte;
  logic       commit;          // Entry done
  logic       pop;             // Entry consumed
  bp_action_e bp_action;
  long_word_t wr_lanes_data;   // Word or replicated byte

  fifo_ctrl u_ctrl (
    .word_valid    (word_valid),
    .byte_valid    (byte_valid),
    .rd_ready      (rd_ready),
    .load_upper    (load_upper),
    .load_lower    (load_lower),
    .reg_wr        (reg_wr),
    .reg_mid25     (reg_mid25),
    .fifo_full     (fifo_full),
    .fifo_empty    (fifo_empty),
    .word_data     (word_data),
    .byte_data     (byte_data),
    .reg_addr      (reg_addr),
    .byte_ptr      (byte_ptr),
    .word_ready    (word_ready),
    .byte_ready    (byte_ready),
    .rd_valid      (rd_valid),
    .ld_upper      (ld_upper),
    .ld_lower      (ld_lower),
    .ld_byte       (ld_byte),
    .commit        (commit),
    .pop           (pop),
    .bp_action     (bp_action),
    .wr_lanes_data (wr_lanes_data)
  );

  fifo u_fifo (
    .clk        (clk),
    .arst_n     (arst_n),
    .flush      (fifo_flush),
    .ld_upper   (ld_upper),
    .ld_lower   (ld_lower),
    .ld_byte    (ld_byte),
    .commit     (commit),
    .pop        (pop),
    .mid25      (reg_mid25),
    .bp_action  (bp_action),
    .wr_data    (wr_lanes_data),
    .rd_data    (rd_data),
    .fifo_full  (fifo_full),
    .fifo_empty (fifo_empty),
    .bo_eq0     (bo_eq0),
    .bo_eq3     (bo_eq3),
    .byte_ptr   (byte_ptr)
  );

endmodule

`default_nettype wire

// File: design/sdmac_reg_pkg.sv
// SDMAC register-side types for the register offset and byte pointer actions
`default_nettype none

package sdmac_reg_pkg;

  typedef logic [7:0] reg_addr_t;   // Register offset on the CPU bus

  // What the byte pointer does at the next edge
  typedef enum logic [1:0] {
    BP_HOLD   = 2'd0,               // Keep current lane
    BP_INC    = 2'd1,               // Byte stored, step to next lane
    BP_PRESET = 2'd2                // ACR write, load from MID25
  } bp_action_e;

endpackage

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module tb_sdmac_fifo \
    -f sdmac_fifo_top.f -Mdir obj_dir; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_sdmac_fifo)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -q "TEST OK"; then
  exit 0
fi
exit 1

// File: sdmac_fifo_top.f
+incdir+design
design/fifo_types_pkg.sv
design/sdmac_reg_pkg.sv
design/fifo_ctrl.sv
design/fifo_write_strobes.sv
design/fifo_fill_ctr.sv
design/fifo_byte_ptr.sv
design/fifo.sv
design/sdmac_fifo_top.sv
testbench/tb_sdmac_fifo.sv

// File: testbench/sdmac_fifo_testdata.txt
# Columns, all hex: op f1 f2 f3
# W upper lower data | B byte | R expected | A offset mid25 | F | X cycles
W 1 1 10000001
W 1 1 20000002
W 1 1 30000003
W 1 1 40000004
W 1 1 50000005
W 1 1 60000006
W 1 1 70000007
W 1 1 80000008
R 10000001
R 20000002
F
W 1 1 AABBCCDD
R AABBCCDD
W 0 1 00005566
R 20005566
W 1 0 77880000
R 77880003
B 11
B 22
B 33
B 44
R 11223344
A 0C 1
B 55
B 66
R 50005566
B 77
A 08 1
B 88
B 99
B AA
R 778899AA
X 40
F

// File: testbench/tb_sdmac_fifo.sv
// Testbench for the SDMAC FIFO top, file-driven stimulus checked against a queue model
`timescale 1ns/10ps
`default_nettype none

`include "fifo_config.svh"

module tb_sdmac_fifo;
  import fifo_types_pkg::*;
  import sdmac_reg_pkg::*;

  localparam int TIMEOUT = 50;     // Cycles allowed per wait

  logic       clk;
  logic       arst_n;
  logic       word_valid, word_ready, load_upper, load_lower;
  long_word_t word_data;
  logic       byte_valid, byte_ready;
  byte_t      byte_data;
  logic       rd_valid, rd_ready;
  long_word_t rd_data;
  logic       reg_wr, reg_mid25, fifo_flush;
  reg_addr_t  reg_addr;
  logic       fifo_full, fifo_empty, bo_eq0, bo_eq3;
  byte_ptr_t  byte_ptr;

  // Reference model state
  long_word_t m_mem [`FIFO_DEPTH];  // Mirrors storage, stale lanes included
  long_word_t exp_q [$];            // Committed entries in read order
  fifo_ptr_t  m_in;
  byte_ptr_t  m_bp;

  integer     seed = 18579;
  int         err_cnt = 0;
  long_word_t rd_seen;              // rd_data sampled before the edge

  sdmac_fifo_top u_dut (
    .clk (clk), .arst_n (arst_n),
    .word_valid (word_valid), .word_ready (word_ready), .word_data (word_data),
    .load_upper (load_upper), .load_lower (load_lower),
    .byte_valid (byte_valid), .byte_ready (byte_ready), .byte_data (byte_data),
    .rd_valid (rd_valid), .rd_ready (rd_ready), .rd_data (rd_data),
    .reg_wr (reg_wr), .reg_addr (reg_addr), .reg_mid25 (reg_mid25),
    .fifo_flush (fifo_flush), .fifo_full (fifo_full), .fifo_empty (fifo_empty),
    .bo_eq0 (bo_eq0), .bo_eq3 (bo_eq3), .byte_ptr (byte_ptr)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;         // 40 ns period
  end

  task automatic stop_on_error();
    err_cnt++;
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    assert (got === exp) else begin
      $display("mismatch at %0t ns: %s expected %h, got %h", $time, name, exp, got);
      stop_on_error();
    end
  endtask

  task automatic report_failure(string what);
    $display("error at %0t ns: %s", $time, what);
    stop_on_error();
  endtask

  function automatic logic model_word_ready();
    return (exp_q.size() < `FIFO_DEPTH) && (m_bp == '0);  // No half built entry
  endfunction

  function automatic logic model_byte_ready();
    return (exp_q.size() < `FIFO_DEPTH) && !(word_valid && model_word_ready());
  endfunction

  // Compare every DUT output with the model
  task automatic check_outputs();
    check_value("fifo_empty", fifo_empty, exp_q.size() == 0);
    check_value("fifo_full", fifo_full, exp_q.size() == `FIFO_DEPTH);
    check_value("rd_valid", rd_valid, exp_q.size() != 0);
    check_value("word_ready", word_ready, model_word_ready());
    check_value("byte_ready", byte_ready, model_byte_ready());
    check_value("byte_ptr", byte_ptr, m_bp);
    check_value("bo_eq0", bo_eq0, m_bp == 2'd0);
    check_value("bo_eq3", bo_eq3, m_bp == 2'd3);
    if (exp_q.size() != 0) check_value("rd_data", rd_data, exp_q[0]);  // Held until pop
  endtask

  // Model update for one rising edge, inputs still as driven
  task automatic update_model();
    logic wx, bx, px, cm;
    int   lane_lo;
    wx = word_valid && model_word_ready();
    bx = byte_valid && model_byte_ready();
    px = rd_ready && (exp_q.size() != 0);
    if (fifo_flush) begin
      exp_q.delete();               // Storage keeps its contents
      m_in = '0;
      m_bp = '0;
    end else begin
      if (wx && load_upper) m_mem[m_in][31:16] = word_data[31:16];
      if (wx && load_lower) m_mem[m_in][15:0]  = word_data[15:0];
      lane_lo = 8 * (3 - int'(m_bp));                   // Pointer 0 is the top byte
      if (bx) m_mem[m_in][lane_lo +: 8] = byte_data;
      cm = wx || (bx && (m_bp == 2'd3));
      if (px) exp_q.delete(0);
      if (cm) begin
        exp_q.push_back(m_mem[m_in]);
        m_in = m_in + 1'b1;
      end
      if (reg_wr && (reg_addr == `ACR_OFFSET)) m_bp = reg_mid25 ? 2'd2 : 2'd0;
      else if (bx) m_bp = m_bp + 1'b1;                  // Wraps after lane 3
    end
  endtask

  // One clock cycle from drive point to drive point
  task automatic run_cycle(output logic w_acc, output logic b_acc, output logic r_acc);
    #1;
    check_outputs();
    w_acc   = word_valid && word_ready;
    b_acc   = byte_valid && byte_ready;
    r_acc   = rd_valid && rd_ready;
    rd_seen = rd_data;
    @(posedge clk);
    update_model();
    #2;                             // Inputs change 2 ns after the edge
  endtask

  task automatic write_word(logic upper, logic lower, long_word_t data);
    logic w, b, r;
    int   waited = 0;
    word_valid = 1'b1;
    load_upper = upper;
    load_lower = lower;
    word_data  = data;
    w = 1'b0;
    while (!w && waited < TIMEOUT) begin
      run_cycle(w, b, r);
      waited++;
    end
    if (!w) report_failure("timeout waiting for word_ready");
    word_valid = 1'b0;
  endtask

  task automatic write_byte(byte_t data);
    logic w, b, r;
    int   waited = 0;
    byte_valid = 1'b1;
    byte_data  = data;
    b = 1'b0;
    while (!b && waited < TIMEOUT) begin
      run_cycle(w, b, r);
      waited++;
    end
    if (!b) report_failure("timeout waiting for byte_ready");
    byte_valid = 1'b0;
  endtask

  task automatic read_word(long_word_t exp);
    logic w, b, r;
    int   waited = 0;
    rd_ready = 1'b1;
    r = 1'b0;
    while (!r && waited < TIMEOUT) begin
      run_cycle(w, b, r);
      waited++;
    end
    if (!r) report_failure("timeout waiting for rd_valid");
    check_value("rd_data", rd_seen, exp);                // Value listed in the data file
    rd_ready = 1'b0;
  endtask

  task automatic write_reg(reg_addr_t addr, logic mid25);
    logic w, b, r;
    reg_wr    = 1'b1;
    reg_addr  = addr;
    reg_mid25 = mid25;
    run_cycle(w, b, r);
    reg_wr    = 1'b0;
    reg_mid25 = 1'b0;
  endtask

  task automatic flush_fifo();
    logic w, b, r;
    fifo_flush = 1'b1;
    run_cycle(w, b, r);
    fifo_flush = 1'b0;
  endtask

  // Random mix of word, byte and read traffic, valids held until accepted
  task automatic random_burst(int cycles);
    logic        w, b, r;
    logic [31:0] rnd;
    int          waited = 0;
    for (int i = 0; i < cycles; i++) begin
      rnd = $random(seed);
      if (!word_valid) begin
        word_valid = rnd[0];
        load_upper = rnd[1];
        load_lower = rnd[2];
        word_data  = $random(seed);
      end
      if (!byte_valid) begin
        byte_valid = rnd[3];
        byte_data  = rnd[15:8];
      end
      rd_ready = rnd[4] | rnd[5];   // Reads favored so full does not stick
      run_cycle(w, b, r);
      if (w) word_valid = 1'b0;
      if (b) byte_valid = 1'b0;
    end
    rd_ready = 1'b1;                // Drain pending requests
    while ((word_valid || byte_valid) && waited < TIMEOUT) begin
      if (word_valid && !byte_valid && (m_bp != '0)) begin
        byte_valid = 1'b1;          // Finish the open entry so the word can go
        byte_data  = byte_t'($random(seed));
      end
      run_cycle(w, b, r);
      if (w) word_valid = 1'b0;
      if (b) byte_valid = 1'b0;
      waited++;
    end
    if (word_valid || byte_valid) report_failure("burst writes never accepted");
    rd_ready = 1'b0;
  endtask

  task automatic execute_line(string line);
    byte_t       op;
    string       rest;
    logic [31:0] f1, f2, f3;
    int          nf;
    op   = line.getc(0);
    rest = line.substr(1, line.len() - 1);
    f1 = '0;
    f2 = '0;
    f3 = '0;
    nf = $sscanf(rest, "%h %h %h", f1, f2, f3);
    case (op)
      "W":     write_word(f1[0], f2[0], f3);
      "B":     write_byte(f1[7:0]);
      "R":     read_word(f1);
      "A":     write_reg(f1[7:0], f2[0]);
      "F":     flush_fifo();
      "X":     random_burst(f1);
      default: report_failure("unknown operation in testdata file");
    endcase
  endtask

  initial begin
    int    fd;
    int    nread;
    string line;
    arst_n = 1'b0;
    word_valid = 1'b0;
    load_upper = 1'b0;
    load_lower = 1'b0;
    word_data  = '0;
    byte_valid = 1'b0;
    byte_data  = '0;
    rd_ready   = 1'b0;
    reg_wr     = 1'b0;
    reg_addr   = '0;
    reg_mid25  = 1'b0;
    fifo_flush = 1'b0;
    m_in = '0;
    m_bp = '0;
    repeat (2) @(posedge clk);      // Reset held for two cycles
    #2 arst_n = 1'b1;

    fd = $fopen("testbench/sdmac_fifo_testdata.txt", "r");
    if (fd == 0) report_failure("cannot open testbench/sdmac_fifo_testdata.txt");
    while (!$feof(fd)) begin
      nread = $fgets(line, fd);
      if (nread > 1 && line.getc(0) != "#") execute_line(line);  // Skip comments, blanks
    end
    $fclose(fd);

    if (err_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
